// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
design/rv_decode_pkg.sv
design/rv_regfile.sv
design/rv_scoreboard.sv
design/rv_imm_gen.sv
design/rv_ctrl_decode.sv
design/rv_decode_stage.sv
design/rv_decode_top.sv
verification/decode_properties.sv
verification/tb_decode_top.sv

// File: design/rv_ctrl_decode.sv
`timescale 1ns/1ps

module rv_ctrl_decode
  import rv_decode_pkg::*;
(
  input  logic [31:0] inst_i,
  output imm_sel_e    imm_sel_o,
  output op1_sel_e    op1_sel_o,
  output op2_sel_e    op2_sel_o,
  output alu_op_e     alu_op_o,
  output logic        uses_rs1_o,
  output logic        uses_rs2_o,
  output logic        rd_wen_o,
  output logic        mem_ren_o,
  output logic        mem_wen_o,
  output logic        jump_o,
  output logic        mem_addr_en_o,
  output logic        illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_shift;

  assign opcode   = inst_i[6:0];
  assign funct3   = inst_i[14:12];
  assign funct7   = inst_i[31:25];
  assign is_shift = (funct3[1:0] == 2'b01);

  always_comb begin
    imm_sel_o     = IMM_NONE;
    op1_sel_o     = OP1_ZERO;
    op2_sel_o     = OP2_IMM;
    alu_op_o      = ALU_ADD;
    uses_rs1_o    = 1'b0;
    uses_rs2_o    = 1'b0;
    rd_wen_o      = 1'b0;
    mem_ren_o     = 1'b0;
    mem_wen_o     = 1'b0;
    jump_o        = 1'b0;
    mem_addr_en_o = 1'b0;
    illegal_o     = 1'b0;
    case (opcode)
      OP_LUI: begin
        imm_sel_o = IMM_U;
        rd_wen_o  = 1'b1;
      end
      OP_AUIPC: begin
        imm_sel_o = IMM_U;
        op1_sel_o = OP1_PC;
        rd_wen_o  = 1'b1;
      end
      OP_JAL, OP_JALR: begin // link value pc + 4
        imm_sel_o  = IMM_FOUR;
        op1_sel_o  = OP1_PC;
        uses_rs1_o = (opcode == OP_JALR); // jalr base
        rd_wen_o   = 1'b1;
        jump_o     = 1'b1;
      end
      OP_BRANCH: begin
        imm_sel_o  = IMM_B;
        op1_sel_o  = OP1_RS1;
        op2_sel_o  = OP2_RS2;
        alu_op_o   = alu_op_e'({1'b0, funct3});
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
        jump_o     = 1'b1;
      end
      OP_LOAD, OP_STORE: begin
        imm_sel_o     = (opcode == OP_LOAD) ? IMM_I : IMM_S;
        op1_sel_o     = OP1_RS1;
        op2_sel_o     = (opcode == OP_LOAD) ? OP2_IMM : OP2_RS2;
        alu_op_o      = alu_op_e'({1'b0, funct3});
        uses_rs1_o    = 1'b1;
        uses_rs2_o    = (opcode == OP_STORE); // store data
        rd_wen_o      = (opcode == OP_LOAD);
        mem_ren_o     = (opcode == OP_LOAD);
        mem_wen_o     = (opcode == OP_STORE);
        mem_addr_en_o = 1'b1;
      end
      OP_IMM: begin
        imm_sel_o  = IMM_I;
        op1_sel_o  = OP1_RS1;
        alu_op_o   = alu_op_e'({is_shift & funct7[5], funct3}); // srai only
        uses_rs1_o = 1'b1;
        rd_wen_o   = 1'b1;
      end
      OP_REG: begin
        op1_sel_o  = OP1_RS1;
        op2_sel_o  = OP2_RS2;
        alu_op_o   = alu_op_e'({funct7[5], funct3});
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
        rd_wen_o   = 1'b1;
      end
      OP_SYSTEM: begin
        op1_sel_o  = OP1_RS1; // csr source only, op2 stays zero
        uses_rs1_o = 1'b1;
      end
      OP_FENCE: ; // no-op
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

// File: design/rv_decode_pkg.sv
package rv_decode_pkg;

  // RV32E register file
  localparam int unsigned NUM_REGS = 16;
  localparam int unsigned REG_AW   = $clog2(NUM_REGS);

  // major opcodes, inst[6:0]
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111; // FENCE and FENCE.I

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_FOUR // link address offset
  } imm_sel_e;

  typedef enum logic [1:0] {OP1_ZERO, OP1_RS1, OP1_PC} op1_sel_e;

  typedef enum logic [1:0] {OP2_IMM, OP2_RS2} op2_sel_e;

endpackage

// File: design/rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage
  import rv_decode_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic [31:0]       inst_i,
  input  logic [XLEN-1:0]   pc_i,
  output logic [REG_AW-1:0] rs1_addr_o,
  output logic [REG_AW-1:0] rs2_addr_o,
  input  logic [XLEN-1:0]   rs1_data_i,
  input  logic [XLEN-1:0]   rs2_data_i,
  input  logic              rs1_busy_i,
  input  logic              rs2_busy_i,
  output logic              issue_fire_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic [31:0]       inst_o,
  output logic [XLEN-1:0]   pc_o,
  output logic [XLEN-1:0]   op1_o,
  output logic [XLEN-1:0]   op2_o,
  output logic [3:0]        alu_op_o,
  output logic [REG_AW-1:0] rd_o,
  output logic              rd_wen_o,
  output logic              mem_ren_o,
  output logic              mem_wen_o,
  output logic [XLEN-1:0]   mem_addr_o,
  output logic              jump_o,
  output logic [XLEN-1:0]   jump_base_o,
  output logic              illegal_o
);

  logic            valid_q;
  logic [31:0]     inst_q;
  logic [XLEN-1:0] pc_q;
  logic            accept;
  logic            stall;

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [XLEN-1:0] imm;
  imm_sel_e        imm_sel;
  op1_sel_e        op1_sel;
  op2_sel_e        op2_sel;
  alu_op_e         alu_op;
  logic            uses_rs1, uses_rs2;
  logic            rd_wen, mem_ren, mem_wen, jump, mem_addr_en, illegal;

  // one-slot holding register
  assign stall        = (uses_rs1 & rs1_busy_i) | (uses_rs2 & rs2_busy_i);
  assign out_valid_o  = valid_q & ~stall;
  assign issue_fire_o = out_valid_o & out_ready_i;
  assign in_ready_o   = ~valid_q | issue_fire_o;
  assign accept       = in_valid_i & in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (issue_fire_o) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  rv_imm_gen #(.XLEN(XLEN)) imm_gen_i (
    .inst_i (inst_q),
    .imm_i_o(imm_i),
    .imm_s_o(imm_s),
    .imm_b_o(imm_b),
    .imm_u_o(imm_u),
    .imm_j_o(imm_j)
  );

  rv_ctrl_decode ctrl_decode_i (
    .inst_i       (inst_q),
    .imm_sel_o    (imm_sel),
    .op1_sel_o    (op1_sel),
    .op2_sel_o    (op2_sel),
    .alu_op_o     (alu_op),
    .uses_rs1_o   (uses_rs1),
    .uses_rs2_o   (uses_rs2),
    .rd_wen_o     (rd_wen),
    .mem_ren_o    (mem_ren),
    .mem_wen_o    (mem_wen),
    .jump_o       (jump),
    .mem_addr_en_o(mem_addr_en),
    .illegal_o    (illegal)
  );

  always_comb begin
    case (imm_sel)
      IMM_I:    imm = imm_i;
      IMM_S:    imm = imm_s;
      IMM_B:    imm = imm_b;
      IMM_U:    imm = imm_u;
      IMM_J:    imm = imm_j;
      IMM_FOUR: imm = XLEN'(4);
      default:  imm = '0;
    endcase
    case (op1_sel)
      OP1_RS1: op1_o = rs1_data_i;
      OP1_PC:  op1_o = pc_q;
      default: op1_o = '0;
    endcase
    op2_o = (op2_sel == OP2_RS2) ? rs2_data_i : imm;
  end

  assign rs1_addr_o = inst_q[15 +: REG_AW];
  assign rs2_addr_o = inst_q[20 +: REG_AW];
  assign rd_o       = inst_q[7 +: REG_AW];
  assign inst_o     = inst_q;
  assign pc_o       = pc_q;
  assign alu_op_o   = alu_op;
  assign jump_o     = jump;

  assign mem_addr_o  = mem_addr_en ? (rs1_data_i + imm) : '0;
  assign jump_base_o = (inst_q[6:0] == OP_JALR) ? rs1_data_i :
                       jump ? pc_q : '0; // jal and branches are pc relative

  assign rd_wen_o  = rd_wen & out_valid_o;
  assign mem_ren_o = mem_ren & out_valid_o;
  assign mem_wen_o = mem_wen & out_valid_o;
  assign illegal_o = illegal & out_valid_o;

endmodule

// File: design/rv_decode_top.sv
`timescale 1ns/1ps

module rv_decode_top
  import rv_decode_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic [31:0]       inst_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic              wb_en_i,
  input  logic [REG_AW-1:0] wb_addr_i,
  input  logic [XLEN-1:0]   wb_data_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic [31:0]       inst_o,
  output logic [XLEN-1:0]   pc_o,
  output logic [XLEN-1:0]   op1_o,
  output logic [XLEN-1:0]   op2_o,
  output logic [3:0]        alu_op_o,
  output logic [REG_AW-1:0] rd_o,
  output logic              rd_wen_o,
  output logic              mem_ren_o,
  output logic              mem_wen_o,
  output logic [XLEN-1:0]   mem_addr_o,
  output logic              jump_o,
  output logic [XLEN-1:0]   jump_base_o,
  output logic              illegal_o
);

  logic [REG_AW-1:0] rs1_addr, rs2_addr;
  logic [XLEN-1:0]   rs1_data, rs2_data;
  logic              rs1_busy, rs2_busy;
  logic              issue_fire;

  rv_regfile #(.XLEN(XLEN)) regfile_i (
    .clk, .rst,
    .rs1_addr_i(rs1_addr),
    .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wr_en_i   (wb_en_i),
    .wr_addr_i (wb_addr_i),
    .wr_data_i (wb_data_i)
  );

  rv_scoreboard scoreboard_i (
    .clk, .rst,
    .rs1_addr_i    (rs1_addr),
    .rs2_addr_i    (rs2_addr),
    .rs1_busy_o    (rs1_busy),
    .rs2_busy_o    (rs2_busy),
    .issue_i       (issue_fire),
    .issue_rd_i    (rd_o),
    .issue_rd_wen_i(rd_wen_o), // already qualified by out_valid_o
    .clear_i       (wb_en_i),
    .clear_addr_i  (wb_addr_i)
  );

  rv_decode_stage #(.XLEN(XLEN)) stage_i (
    .clk, .rst,
    .in_valid_i, .in_ready_o, .inst_i, .pc_i,
    .rs1_addr_o  (rs1_addr),
    .rs2_addr_o  (rs2_addr),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .rs1_busy_i  (rs1_busy),
    .rs2_busy_i  (rs2_busy),
    .issue_fire_o(issue_fire),
    .out_valid_o, .out_ready_i, .inst_o, .pc_o,
    .op1_o, .op2_o, .alu_op_o, .rd_o, .rd_wen_o,
    .mem_ren_o, .mem_wen_o, .mem_addr_o,
    .jump_o, .jump_base_o, .illegal_o
  );

endmodule

// File: design/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen #(
  parameter int XLEN = 32
) (
  input  logic [31:0]     inst_i,
  output logic [XLEN-1:0] imm_i_o,
  output logic [XLEN-1:0] imm_s_o,
  output logic [XLEN-1:0] imm_b_o,
  output logic [XLEN-1:0] imm_u_o,
  output logic [XLEN-1:0] imm_j_o
);

  logic sign;

  assign sign = inst_i[31];

  // loads, OP-IMM, JALR
  assign imm_i_o = {{(XLEN-11){sign}}, inst_i[30:20]};

  // stores
  assign imm_s_o = {{(XLEN-11){sign}}, inst_i[30:25], inst_i[11:7]};

  // branch offset, bit 0 always zero
  assign imm_b_o = {{(XLEN-12){sign}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  // upper 20 bits
  assign imm_u_o = {{(XLEN-31){sign}}, inst_i[30:12], 12'b0};

  assign imm_j_o = {{(XLEN-20){sign}}, inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0}; // jal offset

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
  import rv_decode_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [REG_AW-1:0] rs1_addr_i,
  input  logic [REG_AW-1:0] rs2_addr_i,
  output logic [XLEN-1:0]   rs1_data_o,
  output logic [XLEN-1:0]   rs2_data_o,
  input  logic              wr_en_i,
  input  logic [REG_AW-1:0] wr_addr_i,
  input  logic [XLEN-1:0]   wr_data_i
);

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin // x0 never written
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // no bypass, the scoreboard holds back readers of pending writes
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: design/rv_scoreboard.sv
`timescale 1ns/1ps

module rv_scoreboard
  import rv_decode_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [REG_AW-1:0] rs1_addr_i,
  input  logic [REG_AW-1:0] rs2_addr_i,
  output logic              rs1_busy_o,
  output logic              rs2_busy_o,
  input  logic              issue_i,
  input  logic [REG_AW-1:0] issue_rd_i,
  input  logic              issue_rd_wen_i,
  input  logic              clear_i,
  input  logic [REG_AW-1:0] clear_addr_i
);

  logic [NUM_REGS-1:0] busy_q;
  logic                set_en;

  assign set_en = issue_i && issue_rd_wen_i && (issue_rd_i != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (clear_i) busy_q[clear_addr_i] <= 1'b0;
      if (set_en) busy_q[issue_rd_i] <= 1'b1; // set wins over a same-cycle clear
    end
  end

  assign rs1_busy_o = busy_q[rs1_addr_i];
  assign rs2_busy_o = busy_q[rs2_addr_i];

endmodule

// File: verification/decode_properties.sv
`timescale 1ns/1ps

module decode_properties
  import rv_decode_pkg::*;
#(
  parameter int XLEN = 32
) (
  input logic              clk,
  input logic              rst,
  input logic              in_ready_o,
  input logic              in_valid_i,
  input logic [31:0]       inst_i,
  input logic [XLEN-1:0]   pc_i,
  input logic              wb_en_i,
  input logic [REG_AW-1:0] wb_addr_i,
  input logic [XLEN-1:0]   wb_data_i,
  input logic              out_valid_o,
  input logic              out_ready_i,
  input logic [31:0]       inst_o,
  input logic [XLEN-1:0]   pc_o,
  input logic [XLEN-1:0]   op1_o,
  input logic [XLEN-1:0]   op2_o,
  input logic [3:0]        alu_op_o,
  input logic [REG_AW-1:0] rd_o,
  input logic              rd_wen_o,
  input logic              mem_ren_o,
  input logic              mem_wen_o,
  input logic [XLEN-1:0]   mem_addr_o,
  input logic              jump_o,
  input logic [XLEN-1:0]   jump_base_o,
  input logic              illegal_o
);

  int unsigned fail_cnt = 0; // read by the testbench

  logic [XLEN-1:0]     shadow_q [NUM_REGS];
  logic [NUM_REGS-1:0] busy_q;
  logic [31:0]         held_inst_q;
  logic [XLEN-1:0]     held_pc_q;
  logic [6:0]          opc;
  logic [2:0]          f3;
  logic [REG_AW-1:0]   rs1, rs2, rd;
  logic [XLEN-1:0]     rs1_val, rs2_val, imm_i, imm_s, imm_u;
  logic [XLEN-1:0]     exp_op1, exp_op2, exp_addr, exp_base;
  logic [3:0]          exp_alu;
  logic                use1, use2, writes, known, fire, shift, alu_used, is_jump;

  task automatic report_fail(input string msg);
    $error("%s", msg);
    fail_cnt++;
  endtask

  assign opc     = inst_o[6:0];
  assign f3      = inst_o[14:12];
  assign rs1     = inst_o[15 +: REG_AW];
  assign rs2     = inst_o[20 +: REG_AW];
  assign rd      = inst_o[7 +: REG_AW];
  assign rs1_val = shadow_q[rs1];
  assign rs2_val = shadow_q[rs2];
  assign imm_i   = {{(XLEN-12){inst_o[31]}}, inst_o[31:20]};
  assign imm_s   = {{(XLEN-12){inst_o[31]}}, inst_o[31:25], inst_o[11:7]};
  assign imm_u   = XLEN'($signed({inst_o[31:12], 12'b0}));
  assign fire    = out_valid_o && out_ready_i;

  assign shift    = (opc == OP_IMM) && (f3[1:0] == 2'b01);
  assign exp_alu  = (opc == OP_REG || shift) ? {inst_o[30], f3} : {1'b0, f3};
  assign alu_used = opc inside {OP_IMM, OP_REG, OP_LOAD, OP_STORE, OP_BRANCH};
  assign is_jump  = opc inside {OP_JAL, OP_JALR, OP_BRANCH};
  assign exp_base = (opc == OP_JALR) ? rs1_val : held_pc_q;
  assign exp_addr = (opc == OP_LOAD) ? rs1_val + imm_i :
                    (opc == OP_STORE) ? rs1_val + imm_s : '0;

  // operand rule per opcode
  always_comb begin
    exp_op1 = '0;
    exp_op2 = '0;
    use1    = 1'b0;
    use2    = 1'b0;
    writes  = 1'b0;
    known   = 1'b1;
    case (opc)
      OP_LUI: begin
        exp_op2 = imm_u;
        writes  = 1'b1;
      end
      OP_AUIPC: begin
        exp_op1 = held_pc_q;
        exp_op2 = imm_u;
        writes  = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        exp_op1 = held_pc_q;
        exp_op2 = XLEN'(4); // link address
        use1    = (opc == OP_JALR);
        writes  = 1'b1;
      end
      OP_BRANCH, OP_STORE, OP_REG: begin
        exp_op1 = rs1_val;
        exp_op2 = rs2_val;
        use1    = 1'b1;
        use2    = 1'b1;
        writes  = (opc == OP_REG);
      end
      OP_LOAD, OP_IMM: begin
        exp_op1 = rs1_val;
        exp_op2 = imm_i;
        use1    = 1'b1;
        writes  = 1'b1;
      end
      OP_SYSTEM: begin
        exp_op1 = rs1_val;
        use1    = 1'b1;
      end
      OP_FENCE: ;
      default: known = 1'b0;
    endcase
  end

  // shadow register file and pending-write set
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        shadow_q[i] <= '0;
      end
      busy_q <= '0;
    end else begin
      if (wb_en_i && wb_addr_i != '0) begin
        shadow_q[wb_addr_i] <= wb_data_i;
        busy_q[wb_addr_i]   <= 1'b0;
      end
      if (fire && writes && rd != '0) busy_q[rd] <= 1'b1; // set wins
      if (in_valid_i && in_ready_o) begin // fetch accept
        held_inst_q <= inst_i;
        held_pc_q   <= pc_i;
      end
    end
  end

  reset_idle_a: assert property (@(posedge clk) $fell(rst) |-> !out_valid_o && in_ready_o)
    else report_fail("stage not idle in the first cycle after reset");

  inst_a: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> inst_o == held_inst_q)
    else report_fail($sformatf("[ERROR] %0t inst_o got %h expected %h",
                               $time, $sampled(inst_o), $sampled(held_inst_q)));

  pc_a: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> pc_o == held_pc_q)
    else report_fail($sformatf("[ERROR] %0t pc_o got %h expected %h",
                               $time, $sampled(pc_o), $sampled(held_pc_q)));

  rd_a: assert property (@(posedge clk) disable iff (rst)
                         out_valid_o |-> rd_o == held_inst_q[10:7])
    else report_fail($sformatf("[ERROR] %0t rd_o got %h expected %h",
                               $time, $sampled(rd_o), $sampled(held_inst_q[10:7])));

  rd_wen_a: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> rd_wen_o == writes)
    else report_fail($sformatf("[ERROR] %0t rd_wen_o got %b expected %b",
                               $time, $sampled(rd_wen_o), $sampled(writes)));

  op1_a: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> op1_o == exp_op1)
    else report_fail($sformatf("[ERROR] %0t op1_o got %h expected %h",
                               $time, $sampled(op1_o), $sampled(exp_op1)));

  op2_a: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> op2_o == exp_op2)
    else report_fail($sformatf("[ERROR] %0t op2_o got %h expected %h",
                               $time, $sampled(op2_o), $sampled(exp_op2)));

  alu_a: assert property (@(posedge clk) disable iff (rst)
                          out_valid_o && alu_used |-> alu_op_o == exp_alu)
    else report_fail($sformatf("[ERROR] %0t alu_op_o got %h expected %h",
                               $time, $sampled(alu_op_o), $sampled(exp_alu)));

  mem_en_a: assert property (@(posedge clk) disable iff (rst) out_valid_o |->
                             mem_ren_o == (opc == OP_LOAD) && mem_wen_o == (opc == OP_STORE))
    else report_fail("memory enables do not match the opcode");

  mem_addr_a: assert property (@(posedge clk) disable iff (rst)
                               out_valid_o |-> mem_addr_o == exp_addr)
    else report_fail($sformatf("[ERROR] %0t mem_addr_o got %h expected %h",
                               $time, $sampled(mem_addr_o), $sampled(exp_addr)));

  jump_a: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> jump_o == is_jump)
    else report_fail($sformatf("[ERROR] %0t jump_o got %b expected %b",
                               $time, $sampled(jump_o), $sampled(is_jump)));

  jump_base_a: assert property (@(posedge clk) disable iff (rst)
                                out_valid_o && is_jump |-> jump_base_o == exp_base)
    else report_fail($sformatf("[ERROR] %0t jump_base_o got %h expected %h",
                               $time, $sampled(jump_base_o), $sampled(exp_base)));

  no_hazard_a: assert property (@(posedge clk) disable iff (rst)
                                out_valid_o |-> !(use1 && busy_q[rs1]) && !(use2 && busy_q[rs2]))
    else report_fail("instruction presented while a source register is still pending");

  hold_inst_a: assert property (@(posedge clk) disable iff (rst)
                                out_valid_o && !out_ready_i |=> $stable(inst_o))
    else report_fail("inst_o changed while the instruction was held");

  hold_ops_a: assert property (@(posedge clk) disable iff (rst)
                               out_valid_o && !out_ready_i |=> $stable(op1_o) && $stable(op2_o))
    else report_fail("operands changed while the instruction was held");

  hold_ready_a: assert property (@(posedge clk) disable iff (rst)
                                 out_valid_o && !out_ready_i |-> !in_ready_o)
    else report_fail("in_ready_o high while the held instruction is stalled");

  illegal_a: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> illegal_o == !known)
    else report_fail($sformatf("[ERROR] %0t illegal_o got %b expected %b",
                               $time, $sampled(illegal_o), !$sampled(known)));

  illegal_quiet_a: assert property (@(posedge clk) disable iff (rst)
                                    illegal_o |-> !rd_wen_o && !mem_ren_o && !mem_wen_o)
    else report_fail("illegal instruction raised a write or memory enable");

endmodule

bind rv_decode_top decode_properties #(.XLEN(XLEN)) props_i (
  .clk, .rst, .in_ready_o, .in_valid_i, .inst_i, .pc_i, .wb_en_i, .wb_addr_i, .wb_data_i,
  .out_valid_o, .out_ready_i, .inst_o, .pc_o, .op1_o, .op2_o, .alu_op_o, .rd_o,
  .rd_wen_o, .mem_ren_o, .mem_wen_o, .mem_addr_o, .jump_o, .jump_base_o, .illegal_o
);

// File: verification/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top
  import rv_decode_pkg::*;
();

  localparam int          XLEN    = 32;
  localparam int          TIMEOUT = 100;
  localparam logic [31:0] SEED    = 32'h34bf7fa9;

  logic              clk;
  logic              rst;
  logic              in_valid_i;
  logic              in_ready_o;
  logic [31:0]       inst_i;
  logic [XLEN-1:0]   pc_i;
  logic              wb_en_i;
  logic [REG_AW-1:0] wb_addr_i;
  logic [XLEN-1:0]   wb_data_i;
  logic              out_valid_o;
  logic              out_ready_i;
  logic [31:0]       inst_o;
  logic [XLEN-1:0]   pc_o, op1_o, op2_o, mem_addr_o, jump_base_o;
  logic [3:0]        alu_op_o;
  logic [REG_AW-1:0] rd_o;
  logic              rd_wen_o, mem_ren_o, mem_wen_o, jump_o, illegal_o;

  int sent       = 0;
  int issued     = 0;
  int timeouts   = 0;
  int count_errs = 0;

  rv_decode_top #(.XLEN(XLEN)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // consumer side, stalls about one cycle in four
  initial begin
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      out_ready_i = ($urandom_range(3) != 0);
      #2;
      if (out_valid_o && out_ready_i) issued++;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input logic [REG_AW-1:0] addr, input logic [XLEN-1:0] data);
    wb_en_i   = 1'b1;
    wb_addr_i = addr;
    wb_data_i = data;
    next_cycle();
    wb_en_i   = 1'b0;
  endtask

  task automatic send_inst(input logic [31:0] inst);
    logic taken;
    int   waited;
    taken      = 1'b0;
    waited     = 0;
    in_valid_i = 1'b1;
    inst_i     = inst;
    pc_i       = $urandom & 32'hffff_fffc;
    while (!taken && waited < TIMEOUT) begin
      #2;
      taken = in_ready_o; // sampled mid-cycle, before the edge
      next_cycle();
      waited++;
    end
    in_valid_i = 1'b0;
    if (taken) begin
      sent++;
    end else begin
      timeouts++;
      $display("fetch handshake timed out, instruction %h was never accepted", inst);
    end
  endtask

  task automatic wait_issue();
    int waited;
    waited = 0;
    while (issued != sent && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (issued != sent) begin
      timeouts++;
      $display("issue timed out, %0d of %0d instructions issued", issued, sent);
    end
  endtask

  function automatic logic writes_rd(input logic [31:0] inst);
    return (inst[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG})
           && (inst[11:7] != 5'd0);
  endfunction

  function automatic logic [31:0] pick_inst(input int kind);
    logic [31:0] w;
    w     = $urandom;
    w[11] = 1'b0; // RV32E has no x16 and up
    w[19] = 1'b0;
    w[24] = 1'b0;
    case (kind)
      0: w[6:0] = OP_LUI;
      1: w[6:0] = OP_AUIPC;
      2: begin
        w[6:0]   = OP_IMM;
        w[14:12] = 3'b000; // addi
      end
      3: begin
        w[6:0]   = OP_REG;
        w[14:12] = 3'b000;
        w[31:25] = 7'b0100000; // sub
      end
      4: begin
        w[6:0]   = OP_IMM;
        w[14:12] = 3'b101;
        w[31:25] = 7'b0100000; // srai
      end
      5: begin
        w[6:0]   = OP_JALR;
        w[14:12] = 3'b000;
      end
      6: begin
        w[6:0]   = OP_LOAD;
        w[14:12] = 3'b010;
      end
      7: begin
        w[6:0]   = OP_STORE;
        w[14:12] = 3'b010;
      end
      8: begin
        w[6:0]   = OP_BRANCH;
        w[14:12] = 3'b000;
      end
      9: w[6:0] = OP_JAL;
      default: w[6:0] = 7'b1011011; // reserved opcode
    endcase
    return w;
  endfunction

  // send, wait for issue, then retire its destination
  task automatic run_inst(input logic [31:0] inst);
    send_inst(inst);
    wait_issue();
    if (writes_rd(inst)) write_reg(inst[10:7], $urandom);
  endtask

  initial begin
    logic [31:0]       w;
    logic [31:0]       d;
    logic [REG_AW-1:0] r;
    int                kind;
    int                total;
    void'($urandom(SEED));
    rst        = 1'b1;
    in_valid_i = 1'b0;
    inst_i     = '0;
    pc_i       = '0;
    wb_en_i    = 1'b0;
    wb_addr_i  = '0;
    wb_data_i  = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 1; i < NUM_REGS; i++) begin
      write_reg(REG_AW'(i), $urandom);
    end

    for (int n = 0; n < 60; n++) begin
      run_inst(pick_inst(int'($urandom_range(10))));
    end

    // writer followed by a dependent reader
    for (int n = 0; n < 9; n++) begin
      r    = REG_AW'($urandom_range(15, 1));
      w    = pick_inst(2);
      w[10:7] = r;
      send_inst(w);
      wait_issue();
      kind = (n % 3 == 0) ? 3 : (n % 3 == 1) ? 7 : 5;
      d    = pick_inst(kind);
      if (kind == 5 || $urandom_range(1) == 0) d[18:15] = r;
      else d[23:20] = r;
      send_inst(d);
      repeat (3) next_cycle();
      if (issued == sent) begin
        count_errs++;
        $display("dependent instruction issued before the writeback of x%0d", r);
      end
      write_reg(r, $urandom);
      wait_issue();
      if (writes_rd(d)) write_reg(d[10:7], $urandom);
    end

    repeat (2) next_cycle();
    if (issued != sent) begin
      count_errs++;
      $display("[ERROR] %0t issued count %0d expected %0d", $time, issued, sent);
    end
    total = timeouts + count_errs + int'(dut_i.props_i.fail_cnt);
    $display("errors: %0d assertion, %0d timeout, %0d count",
             dut_i.props_i.fail_cnt, timeouts, count_errs);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
